/* hdl/memPkg.sv */
package memPkg;

    // bus widths
    localparam int addrWidth = 32;
    localparam int dataWidth = 32;
    localparam int byteWidth = 8;

    // transfer length and stage counter
    localparam int lenWidth = 3;

    // a whole word moves as four bytes
    localparam logic [lenWidth-1:0] wordLen = 3'd4;

    // address bits 17:16 of the I/O window, never cached
    localparam logic [1:0] ioRegion = 2'b11;

    // fetch address split, sized for the default 128-line cache
    localparam int offsetWidth = 2;
    localparam int indexWidth  = 7;
    localparam int tagWidth    = addrWidth - indexWidth - offsetWidth;

    typedef struct packed {
        logic [tagWidth-1:0]    tag;
        logic [indexWidth-1:0]  index;
        logic [offsetWidth-1:0] offset;
    } fetchFieldsT;

    // same word seen as a byte address or as cache fields
    typedef union packed {
        logic [addrWidth-1:0] flat;
        fetchFieldsT          fields;
    } fetchAddrT;

endpackage

/* hdl/instCache.sv */
`timescale 1ns/1ps

module instCache #(
    parameter int cacheLines = 128
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         rdy,
    // pipeline fetch
    input  logic                         fetchEn,
    input  logic [memPkg::addrWidth-1:0] fetchAddr,
    // word returned by the arbiter
    input  logic                         fillEn,
    input  logic [memPkg::addrWidth-1:0] fillAddr,
    input  logic [memPkg::dataWidth-1:0] fillInst,
    output logic                         instValid,
    output logic [memPkg::dataWidth-1:0] inst,
    // miss request towards the arbiter
    output logic                         missEn,
    output logic [memPkg::addrWidth-1:0] missAddr
);

    memPkg::fetchAddrT fetchView;
    memPkg::fetchAddrT fillView;

    logic [memPkg::dataWidth-1:0] dataArr [cacheLines];
    logic [memPkg::tagWidth-1:0]  tagArr [cacheLines];
    logic [cacheLines-1:0]        validArr;

    logic hit;
    logic fillOk;

    assign fetchView = fetchAddr;
    assign fillView  = fillAddr;

    // I/O addresses never get a line, so their tags cannot match
    assign hit = fetchEn
        && validArr[fetchView.fields.index]
        && (tagArr[fetchView.fields.index] == fetchView.fields.tag);

    // fill word goes straight to the pipeline as well
    assign instValid = hit || fillEn;
    assign inst      = hit ? dataArr[fetchView.fields.index] : fillInst;

    // no new miss in the cycle the fill answers the held fetch
    assign missEn   = fetchEn && !hit && !fillEn;
    assign missAddr = fetchView.flat;

    assign fillOk = fillEn && (fillView.flat[17:16] != memPkg::ioRegion);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            validArr <= '0;
        end else if (rdy && fillOk) begin
            validArr[fillView.fields.index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rdy && fillOk) begin
            dataArr[fillView.fields.index] <= fillInst;
            tagArr[fillView.fields.index]  <= fillView.fields.tag;
        end
    end

    // the arbiter holds its done pulses during a stall
    fillOnlyWhenReady: assert property (
        @(posedge clk) disable iff (rst) fillEn |-> rdy
    );

    // index field of the fetch union has to cover every line
    indexFitsLines: assert property (
        @(posedge clk) cacheLines == (1 << memPkg::indexWidth)
    );

endmodule

/* hdl/memArbiter.sv */
`timescale 1ns/1ps

module memArbiter (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         rdy,
    input  logic                         flush,
    // instruction cache port
    input  logic                         missEn,
    input  logic [memPkg::addrWidth-1:0] missAddr,
    // load/store port
    input  logic                         lsEn,
    input  logic                         lsWrite,
    input  logic [memPkg::addrWidth-1:0] lsAddr,
    input  logic [memPkg::lenWidth-1:0]  lsLen,
    input  logic [memPkg::dataWidth-1:0] storeData,
    // RAM read data, one cycle behind ramAddr
    input  logic [memPkg::byteWidth-1:0] ramReadData,
    output logic                         fillEn,
    output logic [memPkg::addrWidth-1:0] fillAddr,
    output logic [memPkg::dataWidth-1:0] fillInst,
    output logic                         lsDone,
    output logic [memPkg::dataWidth-1:0] loadData,
    output logic                         ramWrite,
    output logic [memPkg::addrWidth-1:0] ramAddr,
    output logic [memPkg::byteWidth-1:0] ramWriteData
);

    // running transfer
    logic                         busy;
    logic                         curLs;
    logic                         curWrite;
    logic [memPkg::lenWidth-1:0]  stage;
    logic [memPkg::lenWidth-1:0]  curLen;
    logic [memPkg::dataWidth-1:0] rdBuf;
    // store bytes not yet on the bus
    logic [memPkg::dataWidth-1:0] wrBuf;

    // one waiting slot per port
    logic                         instWait;
    logic [memPkg::addrWidth-1:0] instWaitAddr;
    logic                         lsWait;
    logic                         lsWaitWrite;
    logic [memPkg::addrWidth-1:0] lsWaitAddr;
    logic [memPkg::lenWidth-1:0]  lsWaitLen;
    logic [memPkg::dataWidth-1:0] lsWaitData;

    logic fillPulse;
    logic lsPulse;

    // read byte that was on the bus when a stall began
    logic                         stallHeld;
    logic [memPkg::byteWidth-1:0] heldByte;
    logic [memPkg::byteWidth-1:0] rdByte;

    logic finish;
    logic free;
    logic newInst;
    logic lsPending;
    logic takeLs;
    logic takeInst;
    logic start;

    // request chosen for the next transfer
    logic                         selWrite;
    logic [memPkg::addrWidth-1:0] selAddr;
    logic [memPkg::lenWidth-1:0]  selLen;
    logic [memPkg::dataWidth-1:0] selData;

    logic [memPkg::dataWidth-1:0] nextBuf;

    assign fillEn = fillPulse && rdy;
    assign lsDone = lsPulse && rdy;

    assign rdByte = stallHeld ? heldByte : ramReadData;

    // a flush ends a running fetch early
    assign finish = busy && ((stage == curLen) || (flush && !curLs));
    assign free   = !busy || finish;

    // missEn stays up until the fill, accept it only when nothing is outstanding
    assign newInst = missEn && !flush && !instWait && !(busy && !curLs);

    assign lsPending = lsWait || lsEn;
    assign takeLs    = free && lsPending;
    assign takeInst  = free && !lsPending && ((instWait && !flush) || newInst);
    assign start     = takeLs || takeInst;

    always_comb begin
        if (lsWait) begin
            selWrite = lsWaitWrite;
            selAddr  = lsWaitAddr;
            selLen   = lsWaitLen;
            selData  = lsWaitData;
        end else if (lsEn) begin
            selWrite = lsWrite;
            selAddr  = lsAddr;
            selLen   = lsLen;
            selData  = storeData;
        end else begin
            selWrite = 1'b0;
            selAddr  = instWait ? instWaitAddr : missAddr;
            selLen   = memPkg::wordLen;
            selData  = '0;
        end
    end

    // little-endian assembly, byte stage-1 arrives at stage
    always_comb begin
        nextBuf = rdBuf;
        if (busy && !curWrite && (stage != '0)) begin
            nextBuf[memPkg::byteWidth * (stage - 1) +: memPkg::byteWidth] = rdByte;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy      <= 1'b0;
            curLs     <= 1'b0;
            curWrite  <= 1'b0;
            stage     <= '0;
            curLen    <= '0;
            instWait  <= 1'b0;
            lsWait    <= 1'b0;
            fillPulse <= 1'b0;
            lsPulse   <= 1'b0;
            ramWrite  <= 1'b0;
            ramAddr   <= '0;
            stallHeld <= 1'b0;
        end else if (rdy) begin
            stallHeld <= 1'b0;
            fillPulse <= finish && !curLs && !flush;
            lsPulse   <= finish && curLs;

            if (flush || (takeInst && instWait)) begin
                instWait <= 1'b0;
            end else if (newInst && !takeInst) begin
                instWait <= 1'b1;
            end

            if (lsWait) begin
                lsWait <= !takeLs;
            end else begin
                lsWait <= lsEn && !takeLs;
            end

            if (start) begin
                busy     <= 1'b1;
                curLs    <= takeLs;
                curWrite <= selWrite;
                stage    <= '0;
                curLen   <= selLen;
                ramAddr  <= selAddr;
                ramWrite <= selWrite;
            end else if (finish) begin
                busy     <= 1'b0;
                ramWrite <= 1'b0;
            end else if (busy) begin
                stage    <= stage + 1'b1;
                ramAddr  <= ramAddr + 1'b1;
                // drop the strobe once the last byte has gone out
                ramWrite <= curWrite && ((stage + 1'b1) < curLen);
            end
        end else if (!stallHeld) begin
            stallHeld <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rdy) begin
            if (lsEn && !takeLs) begin
                lsWaitWrite <= lsWrite;
                lsWaitAddr  <= lsAddr;
                lsWaitLen   <= lsLen;
                lsWaitData  <= storeData;
            end
            if (newInst && !takeInst) begin
                instWaitAddr <= missAddr;
            end

            if (finish) begin
                if (curLs) begin
                    loadData <= nextBuf;
                end else if (!flush) begin
                    fillInst <= nextBuf;
                end
            end

            if (start) begin
                rdBuf        <= '0;
                wrBuf        <= selData >> memPkg::byteWidth;
                ramWriteData <= selData[memPkg::byteWidth-1:0];
                if (takeInst) begin
                    fillAddr <= selAddr;
                end
            end else if (busy) begin
                rdBuf        <= nextBuf;
                wrBuf        <= wrBuf >> memPkg::byteWidth;
                ramWriteData <= wrBuf[memPkg::byteWidth-1:0];
            end
        end else if (!stallHeld) begin
            heldByte <= ramReadData;
        end
    end

    lsLenInRange: assert property (
        @(posedge clk) disable iff (rst)
        (rdy && lsEn) |-> ((lsLen != '0) && (lsLen <= memPkg::wordLen))
    );

    // the load/store unit waits for lsDone before its next request
    lsSlotFree: assert property (
        @(posedge clk) disable iff (rst) (rdy && lsEn) |-> !lsWait
    );

    onePortDone: assert property (
        @(posedge clk) disable iff (rst) !(fillEn && lsDone)
    );

endmodule

/* hdl/memSubsystem.sv */
`timescale 1ns/1ps

module memSubsystem #(
    parameter int cacheLines = 128
) (
    input  logic                         clk,
    input  logic                         rst,
    // global stall, low freezes everything
    input  logic                         rdy,
    // branch mispredict
    input  logic                         flush,
    // instruction fetch
    input  logic                         fetchEn,
    input  logic [memPkg::addrWidth-1:0] fetchAddr,
    // load/store unit
    input  logic                         lsEn,
    input  logic                         lsWrite,
    input  logic [memPkg::addrWidth-1:0] lsAddr,
    input  logic [memPkg::lenWidth-1:0]  lsLen,
    input  logic [memPkg::dataWidth-1:0] storeData,
    // byte-wide RAM
    input  logic [memPkg::byteWidth-1:0] ramReadData,
    output logic                         instValid,
    output logic [memPkg::dataWidth-1:0] inst,
    output logic                         lsDone,
    output logic [memPkg::dataWidth-1:0] loadData,
    output logic                         ramWrite,
    output logic [memPkg::addrWidth-1:0] ramAddr,
    output logic [memPkg::byteWidth-1:0] ramWriteData
);

    // cache miss path
    logic                         missEn;
    logic [memPkg::addrWidth-1:0] missAddr;

    // fill path back into the cache
    logic                         fillEn;
    logic [memPkg::addrWidth-1:0] fillAddr;
    logic [memPkg::dataWidth-1:0] fillInst;

    instCache #(
        .cacheLines (cacheLines)
    ) icache (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .fetchEn   (fetchEn),
        .fetchAddr (fetchAddr),
        .fillEn    (fillEn),
        .fillAddr  (fillAddr),
        .fillInst  (fillInst),
        .instValid (instValid),
        .inst      (inst),
        .missEn    (missEn),
        .missAddr  (missAddr)
    );

    // shares the single RAM port between fetch misses and load/store
    memArbiter arbiter (
        .clk          (clk),
        .rst          (rst),
        .rdy          (rdy),
        .flush        (flush),
        .missEn       (missEn),
        .missAddr     (missAddr),
        .lsEn         (lsEn),
        .lsWrite      (lsWrite),
        .lsAddr       (lsAddr),
        .lsLen        (lsLen),
        .storeData    (storeData),
        .ramReadData  (ramReadData),
        .fillEn       (fillEn),
        .fillAddr     (fillAddr),
        .fillInst     (fillInst),
        .lsDone       (lsDone),
        .loadData     (loadData),
        .ramWrite     (ramWrite),
        .ramAddr      (ramAddr),
        .ramWriteData (ramWriteData)
    );

endmodule

/* tests/clockGen.sv */
`timescale 1ns/1ps

module clockGen #(
    parameter int periodNs    = 100,
    parameter int resetCycles = 16
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(periodNs / 2) clk = ~clk;
    end

    // release a little after the edge, like the other inputs
    initial begin
        rst = 1'b1;
        repeat (resetCycles) @(posedge clk);
        #10 rst = 1'b0;
    end

endmodule

/* tests/ramModel.sv */
`timescale 1ns/1ps

module ramModel #(
    parameter logic [7:0] ioSeed = 8'h5a
) (
    input  logic       clk,
    input  logic       write,
    input  logic [31:0] addr,
    input  logic [7:0] writeData,
    output logic [7:0] readData
);

    localparam int addrBits = 18;

    // also read by the testbench as the reference copy
    logic [7:0] mem [2**addrBits];

    // I/O window gets a pattern unlike the byte counter below it
    function automatic logic [7:0] ioPattern(input int k);
        return (k[7:0] * 8'd29) ^ k[15:8] ^ {k[17:16], 6'b0} ^ ioSeed;
    endfunction

    initial begin
        for (int k = 0; k < 2**addrBits; k++) begin
            if (k[17:16] == 2'b11) begin
                mem[k] = ioPattern(k);
            end else begin
                mem[k] = k[7:0];
            end
        end
        readData = '0;
    end

    // one cycle read latency
    always @(posedge clk) begin
        if (write) begin
            mem[addr[addrBits-1:0]] <= writeData;
        end
        readData <= mem[addr[addrBits-1:0]];
    end

endmodule

/* tests/memSubsystemTb.sv */
`timescale 1ns/1ps

module memSubsystemTb;

    localparam int numOps     = 24;
    localparam int cycleLimit = 16 + numOps * 20 + 40;

    // what the running fetch is expected to do
    localparam int kindNone    = 0;
    localparam int kindMiss    = 1;
    localparam int kindHit     = 2;
    localparam int kindRace    = 3;
    localparam int kindFlushed = 4;

    logic        clk;
    logic        rst;
    logic        rdy;
    logic        flush;
    logic        fetchEn;
    logic [31:0] fetchAddr;
    logic        lsEn;
    logic        lsWrite;
    logic [31:0] lsAddr;
    logic [2:0]  lsLen;
    logic [31:0] storeData;
    logic [7:0]  ramReadData;
    logic        instValid;
    logic [31:0] inst;
    logic        lsDone;
    logic [31:0] loadData;
    logic        ramWrite;
    logic [31:0] ramAddr;
    logic [7:0]  ramWriteData;

    string       testName;
    int          fetchKind;
    logic [31:0] expInst;
    logic [31:0] expLoad;
    logic        expWrite;
    logic        lsSeen;
    logic        fetchEnQ;
    int          storeIdx;
    int          cycles = 0;

    clockGen #(.periodNs(100), .resetCycles(16)) clocks (.clk(clk), .rst(rst));

    memSubsystem #(.cacheLines(128)) UUT (
        .clk(clk), .rst(rst), .rdy(rdy), .flush(flush),
        .fetchEn(fetchEn), .fetchAddr(fetchAddr),
        .lsEn(lsEn), .lsWrite(lsWrite), .lsAddr(lsAddr), .lsLen(lsLen),
        .storeData(storeData), .ramReadData(ramReadData),
        .instValid(instValid), .inst(inst), .lsDone(lsDone), .loadData(loadData),
        .ramWrite(ramWrite), .ramAddr(ramAddr), .ramWriteData(ramWriteData)
    );

    ramModel ram (
        .clk(clk), .write(ramWrite), .addr(ramAddr),
        .writeData(ramWriteData), .readData(ramReadData)
    );

    task automatic abortRun();
        $display("Test failures found");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic valueError(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        $display("** Error [%s] %s: expected %h, actual %h", testName, name, expected, actual);
        abortRun();
    endtask

    task automatic failNote(input string what);
        $display("%s: %s", testName, what);
        abortRun();
    endtask

    // little-endian bytes from the reference copy with upper bytes zero
    function automatic logic [31:0] mirrorBytes(input logic [31:0] addr, input int len);
        logic [31:0] word;
        word = '0;
        for (int i = 0; i < len; i++) begin
            word[8*i +: 8] = ram.mem[(addr + i) & 32'h3ffff];
        end
        return word;
    endfunction

    function automatic logic [31:0] keepLow(input logic [31:0] data, input int len);
        return data & (32'hffffffff >> (8 * (4 - len)));
    endfunction

    // byte idx of a little-endian store word
    function automatic logic [7:0] storeByte(input logic [31:0] data, input int idx);
        return data[8*idx +: 8];
    endfunction

    task automatic step();
        @(posedge clk);
        #10;
    endtask

    // hold the fetch until instValid and one more cycle
    task automatic runFetch(input logic [31:0] addr, input int kind);
        expInst   = mirrorBytes(addr, 4);
        fetchKind = kind;
        fetchAddr = addr;
        fetchEn   = 1'b1;
        step();
        while (!instValid) step();
        step();
        fetchEn   = 1'b0;
        fetchKind = kindNone;
        step();
    endtask

    task automatic runLs(input logic write, input logic [31:0] addr, input int len,
                         input logic [31:0] data, input logic [31:0] expected);
        expWrite  = write;
        expLoad   = expected;
        lsWrite   = write;
        lsAddr    = addr;
        lsLen     = len[2:0];
        storeData = data;
        lsEn      = 1'b1;
        step();
        lsEn = 1'b0;
        while (!lsDone) step();
        step();
    endtask

    // lsSeen records an lsDone since the last fetch began
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            lsSeen   <= 1'b0;
            fetchEnQ <= 1'b0;
        end else begin
            fetchEnQ <= fetchEn;
            if (fetchEn && !fetchEnQ) begin
                lsSeen <= 1'b0;
            end else if (lsDone) begin
                lsSeen <= 1'b1;
            end
        end
    end

    // bytes written on the RAM port since the last load/store request
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            storeIdx <= 0;
        end else if (lsEn) begin
            storeIdx <= 0;
        end else if (ramWrite) begin
            storeIdx <= storeIdx + 1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycleLimit) begin
            $display("timeout: run still going after %0d cycles", cycles);
            abortRun();
        end
    end

    instMatches: assert property (@(posedge clk) disable iff (rst)
        instValid |-> (inst == expInst))
        else valueError("inst", expInst, $sampled(inst));

    loadMatches: assert property (@(posedge clk) disable iff (rst)
        (lsDone && !expWrite) |-> (loadData == expLoad))
        else valueError("loadData", expLoad, $sampled(loadData));

    // five quiet cycles after the request before the filled word
    missOnTime: assert property (@(posedge clk) disable iff (rst)
        ($rose(fetchEn) && (fetchKind == kindMiss)) |=> !instValid [*5] ##1 instValid)
        else failNote("fetch miss did not complete 5 cycles after the request");

    missReachesRam: assert property (@(posedge clk) disable iff (rst)
        ($rose(fetchEn) && (fetchKind == kindMiss)) |=> (ramAddr == fetchAddr))
        else valueError("ramAddr", $sampled(fetchAddr), $sampled(ramAddr));

    hitSameCycle: assert property (@(posedge clk) disable iff (rst)
        (fetchEn && (fetchKind == kindHit)) |-> instValid)
        else failNote("repeat fetch did not hit in the same cycle");

    hitQuietRam: assert property (@(posedge clk) disable iff (rst)
        (fetchEn && (fetchKind == kindHit)) |=> ($stable(ramAddr) && !ramWrite))
        else failNote("cache hit still drove the RAM port");

    lsBeforeFetch: assert property (@(posedge clk) disable iff (rst)
        (instValid && (fetchKind == kindRace)) |-> lsSeen)
        else failNote("fetch finished before the competing load");

    flushedQuiet: assert property (@(posedge clk) disable iff (rst)
        (fetchKind == kindFlushed) |-> !instValid)
        else failNote("flushed fetch still returned instValid");

    // store bytes go out one per cycle on consecutive addresses
    storeInOrder: assert property (@(posedge clk) disable iff (rst)
        ramWrite |-> ((storeIdx < lsLen) && (ramAddr == lsAddr + storeIdx)))
        else failNote("store byte went to the wrong RAM address");

    storeByteMatches: assert property (@(posedge clk) disable iff (rst)
        ramWrite |-> (ramWriteData == storeByte(storeData, storeIdx)))
        else valueError("ramWriteData", storeByte($sampled(storeData), $sampled(storeIdx)),
                        $sampled(ramWriteData));

    for (genvar n = 1; n <= 4; n++) begin : lsTiming
        localparam int quiet = n + 1;
        doneOnTime: assert property (@(posedge clk) disable iff (rst)
            (lsEn && (lsLen == n)) |=> !lsDone [*quiet] ##1 lsDone)
            else failNote("lsDone did not arrive length+1 cycles after lsEn");
    end

    initial begin
        logic [31:0] baseAddr;
        logic [31:0] addr;
        logic [31:0] data;
        int          len;
        int          loadLens [6];

        void'($urandom(16118));
        rdy       = 1'b1;
        flush     = 1'b0;
        fetchEn   = 1'b0;
        fetchAddr = '0;
        lsEn      = 1'b0;
        lsWrite   = 1'b0;
        lsAddr    = '0;
        lsLen     = 3'd1;
        storeData = '0;
        expInst   = '0;
        expLoad   = '0;
        expWrite  = 1'b0;
        fetchKind = kindNone;
        testName  = "reset";
        loadLens  = '{1, 2, 4, 1, 2, 4};

        wait (!rst);
        step();

        testName = "miss then hit";
        baseAddr = ($urandom % 32'h2f000) & ~32'h3;
        runFetch(baseAddr, kindMiss);
        runFetch(baseAddr, kindHit);

        testName = "loads";
        foreach (loadLens[i]) begin
            addr = $urandom % 32'h2fffc;
            runLs(1'b0, addr, loadLens[i], '0, mirrorBytes(addr, loadLens[i]));
        end

        // bit 8 moves the fetch to another line
        testName = "priority";
        addr      = $urandom % 32'h2fffc;
        expLoad   = mirrorBytes(addr, 4);
        expWrite  = 1'b0;
        expInst   = mirrorBytes(baseAddr ^ 32'h100, 4);
        fetchKind = kindRace;
        fetchAddr = baseAddr ^ 32'h100;
        fetchEn   = 1'b1;
        lsWrite   = 1'b0;
        lsAddr    = addr;
        lsLen     = 3'd4;
        lsEn      = 1'b1;
        step();
        lsEn = 1'b0;
        while (!instValid) step();
        step();
        fetchEn   = 1'b0;
        fetchKind = kindNone;
        step();

        testName  = "flush";
        fetchKind = kindFlushed;
        fetchAddr = baseAddr ^ 32'h80;
        fetchEn   = 1'b1;
        step();
        step();
        flush   = 1'b1;
        fetchEn = 1'b0;
        step();
        flush = 1'b0;
        repeat (8) step();
        fetchKind = kindNone;
        runFetch(baseAddr ^ 32'h80, kindMiss);

        testName = "uncacheable";
        addr = 32'h30000 | ($urandom & 32'hfffc);
        runFetch(addr, kindMiss);
        runFetch(addr, kindMiss);

        testName = "stores";
        repeat (5) begin
            addr = $urandom % 32'h2fffc;
            len  = 1 + ($urandom % 4);
            data = $urandom;
            runLs(1'b1, addr, len, data, '0);
            runLs(1'b0, addr, len, '0, keepLow(data, len));
        end

        repeat (8) @(posedge clk);
        $display("All tests passed!");
        $finish;
    end

endmodule

/* flist.f */
hdl/memPkg.sv
hdl/instCache.sv
hdl/memArbiter.sv
hdl/memSubsystem.sv
tests/clockGen.sv
tests/ramModel.sv
tests/memSubsystemTb.sv
